/* soc_bus.f */
+incdir+src
src/soc_bus_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/block_ram.sv
src/led_register.sv
src/interval_timer.sv
src/soc_bus_top.sv
bench/soc_bus_tb.sv

/* Makefile */
# Verilator simulation of the system bus testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= soc_bus_tb
FILELIST  ?= soc_bus.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/soc_bus_trace.txt */
# op port address data expect, all numbers in hex
# expect is the read data, or o_leds after an LED write; contend: first port wins
read B 10000000 00000000 00000000
write B 10000000 11112222 00000000
write C 10000004 33334444 00000000
write B 10000FFC 5A5A5A5A 00000000
read C 10000000 00000000 11112222
read B 10000004 00000000 33334444
read A 10000FFC 00000000 5A5A5A5A
write C 10000000 DEADBEEF 00000000
read A 10000000 00000000 DEADBEEF
read B 10000008 00000000 00000000
read C 10000100 00000000 00000000
contend BA 10000040 CAFE0001 CAFE0001
contend CA 10000044 CAFE0002 CAFE0002
contend BC 10000048 CAFE0003 CAFE0003
read A 10000040 00000000 CAFE0001
read B 10000048 00000000 CAFE0003
write B 40000000 FFFFF3A5 000003A5
read C 40000000 00000000 000003A5
write C 40000000 00000012 00000012
read A 40000000 00000000 00000012
irq B A0000004 00000006 00000000
irq C A0000004 00000003 00000000
read B A0000004 00000000 00000003
fault B 50000000 00000000 00000000
fault A 70001234 00000000 00000000
fault C F0000000 00000000 00000000
read B 10000004 00000000 33334444
read C 10000FFC 00000000 5A5A5A5A

/* bench/soc_bus_tb.sv */
// System bus testbench: replays a trace of master transfers and checks the replies
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module soc_bus_tb;

	localparam int READY_TIMEOUT = 50;
	localparam int IRQ_TIMEOUT = 20;

	logic clock;
	logic i_rst_n;
	logic i_pa_request;
	soc_bus_pkg::bus_addr_t i_pa_address;
	logic o_pa_ready;
	soc_bus_pkg::bus_word_t o_pa_rdata;
	logic i_pb_request;
	logic i_pb_rw;
	soc_bus_pkg::bus_addr_t i_pb_address;
	soc_bus_pkg::bus_word_t i_pb_wdata;
	logic o_pb_ready;
	soc_bus_pkg::bus_word_t o_pb_rdata;
	logic i_pc_request;
	logic i_pc_rw;
	soc_bus_pkg::bus_addr_t i_pc_address;
	soc_bus_pkg::bus_word_t i_pc_wdata;
	logic o_pc_ready;
	soc_bus_pkg::bus_word_t o_pc_rdata;
	logic [`SOC_LED_W-1:0] o_leds;
	logic o_timer_irq;
	logic o_bus_fault;
	int cycle_count = 0;

	soc_bus_top u_soc_bus_top (.*);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// ==============================
	// Reporting
	// ==============================
	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string what, input soc_bus_pkg::bus_word_t got,
			input soc_bus_pkg::bus_word_t exp_v);
		if (got !== exp_v) begin
			$display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp_v);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic soc_bus_pkg::bus_word_t flag_word(input logic flag);
		return {{(`SOC_DATA_W-1){1'b0}}, flag};
	endfunction

	// ==============================
	// Master ports
	// ==============================
	task automatic drive_port(input byte port, input logic req, input logic rw,
			input soc_bus_pkg::bus_addr_t addr, input soc_bus_pkg::bus_word_t wdata);
		case (port)
			"A": begin
				i_pa_request <= req;
				i_pa_address <= addr;
			end
			"B": begin
				i_pb_request <= req;
				i_pb_rw <= rw;
				i_pb_address <= addr;
				i_pb_wdata <= wdata;
			end
			"C": begin
				i_pc_request <= req;
				i_pc_rw <= rw;
				i_pc_address <= addr;
				i_pc_wdata <= wdata;
			end
			default: stop_run($sformatf("trace names unknown port %c", port));
		endcase
	endtask

	function automatic logic port_ready(input byte port);
		case (port)
			"A": return o_pa_ready;
			"B": return o_pb_ready;
			default: return o_pc_ready;
		endcase
	endfunction

	function automatic soc_bus_pkg::bus_word_t port_rdata(input byte port);
		case (port)
			"A": return o_pa_rdata;
			"B": return o_pb_rdata;
			default: return o_pc_rdata;
		endcase
	endfunction

	// Sampled on the falling edge, where outputs are settled
	task automatic wait_ready(input byte port, output soc_bus_pkg::bus_word_t rdata,
			output int at_cycle, output logic fault_seen);
		int waited;
		logic any_ready;
		waited = 0;
		fault_seen = 1'b0;
		@(negedge clock);
		forever begin
			any_ready = o_pa_ready || o_pb_ready || o_pc_ready;
			fault_seen = fault_seen || o_bus_fault;
			check_value("ready on a port that was not waited for",
				flag_word(any_ready && !port_ready(port)), '0);
			if (port_ready(port)) begin
				break;
			end
			if (waited >= READY_TIMEOUT) begin
				stop_run($sformatf("port %c never got ready", port));
			end
			waited++;
			@(negedge clock);
		end
		rdata = port_rdata(port);
		at_cycle = cycle_count;
	endtask

	// One complete transfer; request dropped on the edge after ready
	task automatic transfer(input byte port, input logic rw, input soc_bus_pkg::bus_addr_t addr,
			input soc_bus_pkg::bus_word_t wdata, output soc_bus_pkg::bus_word_t rdata,
			output int at_cycle, output logic fault_seen);
		@(posedge clock);
		drive_port(port, 1'b1, rw, addr, wdata);
		wait_ready(port, rdata, at_cycle, fault_seen);
		@(posedge clock);
		drive_port(port, 1'b0, rw, addr, wdata);
	endtask

	// ==============================
	// Trace operations
	// ==============================
	// Winner writes, loser reads the same word afterwards
	task automatic contend(input byte win, input byte lose, input soc_bus_pkg::bus_addr_t addr,
			input soc_bus_pkg::bus_word_t data, input soc_bus_pkg::bus_word_t exp_data);
		soc_bus_pkg::bus_word_t rdata;
		int win_cycle;
		int lose_cycle;
		logic win_fault;
		logic lose_fault;
		@(posedge clock);
		drive_port(win, 1'b1, 1'b1, addr, data);
		drive_port(lose, 1'b1, 1'b0, addr, '0);
		// A loser ready in this wait fails the stray-ready check
		wait_ready(win, rdata, win_cycle, win_fault);
		@(posedge clock);
		drive_port(win, 1'b0, 1'b1, addr, data);
		wait_ready(lose, rdata, lose_cycle, lose_fault);
		@(posedge clock);
		drive_port(lose, 1'b0, 1'b0, addr, '0);
		check_value("loser read data", rdata, exp_data);
		check_value("fault during contention", flag_word(win_fault || lose_fault), '0);
	endtask

	task automatic timer_irq(input byte port, input soc_bus_pkg::bus_addr_t addr,
			input soc_bus_pkg::bus_word_t compare);
		soc_bus_pkg::bus_word_t rdata;
		int ready_cycle;
		int read_cycle;
		int elapsed;
		int limit;
		logic fault_seen;
		limit = int'(compare) * `SOC_TIMER_PRESCALE;
		@(posedge clock);
		drive_port(port, 1'b1, 1'b1, addr, compare);
		wait_ready(port, rdata, ready_cycle, fault_seen);
		check_value("irq cleared by compare write", flag_word(o_timer_irq), '0);
		check_value("fault on timer write", flag_word(fault_seen), '0);
		@(posedge clock);
		drive_port(port, 1'b0, 1'b1, addr, compare);
		// Count register at index 0, read while counting
		transfer("A", 1'b0, {addr[`SOC_ADDR_W-1:4], 4'h0}, '0, rdata, read_cycle, fault_seen);
		check_value("timer count not above compare", flag_word(rdata <= compare), 1);
		check_value("fault on timer read", flag_word(fault_seen), '0);
		@(negedge clock);
		elapsed = cycle_count - ready_cycle;
		while (!o_timer_irq) begin
			if (elapsed > limit + IRQ_TIMEOUT) begin
				stop_run("timer interrupt never rose");
			end
			@(negedge clock);
			elapsed = cycle_count - ready_cycle;
		end
		check_value("irq not before compare times prescale", flag_word(elapsed >= limit), 1);
	endtask

	task automatic run_line(input string line);
		string op;
		string ports;
		soc_bus_pkg::bus_addr_t addr;
		soc_bus_pkg::bus_word_t data;
		soc_bus_pkg::bus_word_t exp_data;
		soc_bus_pkg::bus_word_t rdata;
		int at_cycle;
		logic fault_seen;
		if ($sscanf(line, "%s %s %h %h %h", op, ports, addr, data, exp_data) != 5) begin
			stop_run({"trace line could not be parsed: ", line});
		end
		case (op)
			"write": begin
				transfer(ports[0], 1'b1, addr, data, rdata, at_cycle, fault_seen);
				check_value("fault on mapped write", flag_word(fault_seen), '0);
				if (addr[`SOC_REGION_MSB:`SOC_REGION_LSB] == `SOC_REGION_LED) begin
					check_value("LED output", {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, o_leds},
						exp_data);
				end
			end
			"read": begin
				transfer(ports[0], 1'b0, addr, '0, rdata, at_cycle, fault_seen);
				check_value("read data", rdata, exp_data);
				check_value("fault on mapped read", flag_word(fault_seen), '0);
			end
			"fault": begin
				transfer(ports[0], 1'b0, addr, '0, rdata, at_cycle, fault_seen);
				check_value("unmapped read data", rdata, exp_data);
				check_value("fault pulse on unmapped read", flag_word(fault_seen), 1);
			end
			"contend": contend(ports[0], ports[1], addr, data, exp_data);
			"irq": timer_irq(ports[0], addr, data);
			default: stop_run({"unknown trace operation: ", op});
		endcase
		// Random idle time between transfers
		repeat ($urandom_range(1, 3)) @(posedge clock);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int fd;
		string line;
		clock = 1'b0;
		i_rst_n = 1'b0;
		i_pa_request = 1'b0;
		i_pa_address = '0;
		i_pb_request = 1'b0;
		i_pb_rw = 1'b0;
		i_pb_address = '0;
		i_pb_wdata = '0;
		i_pc_request = 1'b0;
		i_pc_rw = 1'b0;
		i_pc_address = '0;
		i_pc_wdata = '0;
		void'($urandom(77065));
		fd = $fopen("bench/soc_bus_trace.txt", "r");
		if (fd == 0) begin
			stop_run("could not open the trace file");
		end
		repeat (8) @(posedge clock);
		i_rst_n <= 1'b1;
		@(negedge clock);
		check_value("ready after reset", flag_word(o_pa_ready || o_pb_ready || o_pc_ready), '0);
		check_value("fault after reset", flag_word(o_bus_fault), '0);
		check_value("irq after reset", flag_word(o_timer_irq), '0);
		check_value("LEDs after reset", {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, o_leds}, '0);
		while ($fgets(line, fd) != 0) begin
			// Skip comments and blank lines
			if (line.len() > 1 && line[0] != "#") begin
				run_line(line);
			end
		end
		$fclose(fd);
		$display(">>> PASS");
		$finish;
	end

endmodule

/* src/soc_bus_top.sv */
// System bus top: arbiter, decoder, RAM, LED register and interval timer
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module soc_bus_top (
	input  logic                   clock,
	input  logic                   i_rst_n,
	// Port A
	input  logic                   i_pa_request,
	input  soc_bus_pkg::bus_addr_t i_pa_address,
	output logic                   o_pa_ready,
	output soc_bus_pkg::bus_word_t o_pa_rdata,
	// Port B
	input  logic                   i_pb_request,
	input  logic                   i_pb_rw,
	input  soc_bus_pkg::bus_addr_t i_pb_address,
	input  soc_bus_pkg::bus_word_t i_pb_wdata,
	output logic                   o_pb_ready,
	output soc_bus_pkg::bus_word_t o_pb_rdata,
	// Port C
	input  logic                   i_pc_request,
	input  logic                   i_pc_rw,
	input  soc_bus_pkg::bus_addr_t i_pc_address,
	input  soc_bus_pkg::bus_word_t i_pc_wdata,
	output logic                   o_pc_ready,
	output soc_bus_pkg::bus_word_t o_pc_rdata,
	// Peripherals
	output logic [`SOC_LED_W-1:0]  o_leds,
	output logic                   o_timer_irq,
	output logic                   o_bus_fault
);

	// Shared bus
	logic bus_request;
	logic bus_rw;
	logic bus_ready;
	soc_bus_pkg::bus_addr_t bus_address;
	soc_bus_pkg::bus_word_t bus_wdata;
	soc_bus_pkg::bus_word_t bus_rdata;

	// Slave side
	logic ram_select;
	logic led_select;
	logic timer_select;
	logic ram_ready;
	logic led_ready;
	logic timer_ready;
	soc_bus_pkg::bus_word_t ram_rdata;
	soc_bus_pkg::bus_word_t led_rdata;
	soc_bus_pkg::bus_word_t timer_rdata;

	bus_arbiter u_bus_arbiter (
		.clock         (clock),
		.i_rst_n       (i_rst_n),
		.i_pa_request  (i_pa_request),
		.i_pa_address  (i_pa_address),
		.o_pa_ready    (o_pa_ready),
		.o_pa_rdata    (o_pa_rdata),
		.i_pb_request  (i_pb_request),
		.i_pb_rw       (i_pb_rw),
		.i_pb_address  (i_pb_address),
		.i_pb_wdata    (i_pb_wdata),
		.o_pb_ready    (o_pb_ready),
		.o_pb_rdata    (o_pb_rdata),
		.i_pc_request  (i_pc_request),
		.i_pc_rw       (i_pc_rw),
		.i_pc_address  (i_pc_address),
		.i_pc_wdata    (i_pc_wdata),
		.o_pc_ready    (o_pc_ready),
		.o_pc_rdata    (o_pc_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	bus_decoder u_bus_decoder (
		.clock          (clock),
		.i_rst_n        (i_rst_n),
		.i_bus_request  (bus_request),
		.i_bus_address  (bus_address),
		.o_bus_ready    (bus_ready),
		.o_bus_rdata    (bus_rdata),
		.o_ram_select   (ram_select),
		.o_led_select   (led_select),
		.o_timer_select (timer_select),
		.i_ram_ready    (ram_ready),
		.i_ram_rdata    (ram_rdata),
		.i_led_ready    (led_ready),
		.i_led_rdata    (led_rdata),
		.i_timer_ready  (timer_ready),
		.i_timer_rdata  (timer_rdata),
		.o_bus_fault    (o_bus_fault)
	);

	// ==============================
	// Slaves
	// ==============================
	block_ram #(
		.DEPTH (`SOC_RAM_WORDS)
	) u_block_ram (
		.clock     (clock),
		.i_request (ram_select),
		.i_rw      (bus_rw),
		.i_address (bus_address),
		.i_wdata   (bus_wdata),
		.o_rdata   (ram_rdata),
		.o_ready   (ram_ready)
	);

	led_register u_led_register (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_request (led_select),
		.i_rw      (bus_rw),
		.i_wdata   (bus_wdata),
		.o_rdata   (led_rdata),
		.o_ready   (led_ready),
		.o_leds    (o_leds)
	);

	interval_timer u_interval_timer (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_request (timer_select),
		.i_rw      (bus_rw),
		.i_address (bus_address),
		.i_wdata   (bus_wdata),
		.o_rdata   (timer_rdata),
		.o_ready   (timer_ready),
		.o_irq     (o_timer_irq)
	);

endmodule

/* src/interval_timer.sv */
// Interval timer: prescaled tick count against a compare value, level interrupt
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module interval_timer (
	input  logic                   clock,
	input  logic                   i_rst_n,
	input  logic                   i_request,
	input  logic                   i_rw,
	input  soc_bus_pkg::bus_addr_t i_address,
	input  soc_bus_pkg::bus_word_t i_wdata,
	output soc_bus_pkg::bus_word_t o_rdata,
	output logic                   o_ready,
	output logic                   o_irq
);

	localparam int PRESCALE = `SOC_TIMER_PRESCALE;
	localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	soc_bus_pkg::reg_index_t index;
	soc_bus_pkg::bus_word_t  count_q;
	soc_bus_pkg::bus_word_t  count_next;
	soc_bus_pkg::bus_word_t  compare_q;
	logic [PRE_W-1:0] prescale_q;
	logic armed_q;
	logic access;
	logic compare_write;

	assign index = i_address[3:2];
	assign access = i_request && !o_ready;
	assign compare_write = access && i_rw && (index == 2'd1);
	assign count_next = count_q + 1'b1;

	// ==============================
	// Counter and interrupt
	// ==============================
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
			o_irq <= 1'b0;
			armed_q <= 1'b0;
			count_q <= '0;
			compare_q <= '0;
			prescale_q <= '0;
		end else begin
			o_ready <= access;
			if (compare_write) begin
				// Restart from zero
				compare_q <= i_wdata;
				count_q <= '0;
				prescale_q <= '0;
				o_irq <= 1'b0;
				armed_q <= 1'b1;
			end else if (armed_q && !o_irq) begin
				if (count_q == compare_q) begin
					// Compare of zero fires at once
					o_irq <= 1'b1;
				end else if (prescale_q == PRE_W'(PRESCALE - 1)) begin
					prescale_q <= '0;
					count_q <= count_next;
					if (count_next == compare_q) begin
						o_irq <= 1'b1;
					end
				end else begin
					prescale_q <= prescale_q + 1'b1;
				end
			end
		end
	end

	// Register reads, count at index 0 and compare at index 1
	always_comb begin
		case (index)
			2'd0: o_rdata = count_q;
			2'd1: o_rdata = compare_q;
			default: o_rdata = '0;
		endcase
	end

	// Interrupt only follows an armed count
	assert property (@(posedge clock) disable iff (!i_rst_n)
		$rose(o_irq) |-> $past(armed_q));

endmodule

/* src/led_register.sv */
// LED output register, writable and readable over the bus
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module led_register (
	input  logic                   clock,
	input  logic                   i_rst_n,
	input  logic                   i_request,
	input  logic                   i_rw,
	input  soc_bus_pkg::bus_word_t i_wdata,
	output soc_bus_pkg::bus_word_t o_rdata,
	output logic                   o_ready,
	output logic [`SOC_LED_W-1:0]  o_leds
);

	logic access;

	assign access = i_request && !o_ready;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_leds <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			// Low bits only
			if (access && i_rw) begin
				o_leds <= i_wdata[`SOC_LED_W-1:0];
			end
		end
	end

	assign o_rdata = {{(`SOC_DATA_W - `SOC_LED_W){1'b0}}, o_leds};

endmodule

/* src/block_ram.sv */
// Single-port word RAM, reply registered one cycle after the request
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module block_ram #(
	parameter int DEPTH = `SOC_RAM_WORDS
) (
	input  logic                   clock,
	input  logic                   i_request,
	input  logic                   i_rw,
	input  soc_bus_pkg::bus_addr_t i_address,
	input  soc_bus_pkg::bus_word_t i_wdata,
	output soc_bus_pkg::bus_word_t o_rdata,
	output logic                   o_ready
);

	localparam int IDX_W = $clog2(DEPTH);

	soc_bus_pkg::bus_word_t mem [DEPTH];
	logic [IDX_W-1:0] word_index;
	logic access;

	// Byte address to word index
	assign word_index = i_address[IDX_W+1:2];

	// One access per request, the ready cycle does not repeat it
	assign access = i_request && !o_ready;

	// Memory starts cleared
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			if (i_rw) begin
				mem[word_index] <= i_wdata;
			end
			o_rdata <= mem[word_index];
		end
	end

	always_ff @(posedge clock) begin
		o_ready <= access;
	end

endmodule

/* src/bus_decoder.sv */
// Address decoder: slave selects, reply mux and unmapped-access fault
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module bus_decoder (
	input  logic                   clock,
	input  logic                   i_rst_n,
	input  logic                   i_bus_request,
	input  soc_bus_pkg::bus_addr_t i_bus_address,
	output logic                   o_bus_ready,
	output soc_bus_pkg::bus_word_t o_bus_rdata,
	output logic                   o_ram_select,
	output logic                   o_led_select,
	output logic                   o_timer_select,
	input  logic                   i_ram_ready,
	input  soc_bus_pkg::bus_word_t i_ram_rdata,
	input  logic                   i_led_ready,
	input  soc_bus_pkg::bus_word_t i_led_rdata,
	input  logic                   i_timer_ready,
	input  soc_bus_pkg::bus_word_t i_timer_rdata,
	output logic                   o_bus_fault
);

	soc_bus_pkg::region_t region;
	logic ram_hit;
	logic led_hit;
	logic timer_hit;
	logic unmapped;
	logic fault_q;

	assign region = i_bus_address[`SOC_REGION_MSB:`SOC_REGION_LSB];

	assign ram_hit = (region == `SOC_REGION_RAM);
	assign led_hit = (region == `SOC_REGION_LED);
	assign timer_hit = (region == `SOC_REGION_TIMER);
	assign unmapped = !(ram_hit || led_hit || timer_hit);

	// Selects qualified by the request
	assign o_ram_select = i_bus_request && ram_hit;
	assign o_led_select = i_bus_request && led_hit;
	assign o_timer_select = i_bus_request && timer_hit;

	// ==============================
	// Unmapped access
	// ==============================
	// Acts as a slave that answers zero after one cycle
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			fault_q <= 1'b0;
		end else begin
			fault_q <= i_bus_request && unmapped && !fault_q;
		end
	end

	assign o_bus_fault = fault_q;

	// Reply mux
	always_comb begin
		o_bus_ready = fault_q;
		o_bus_rdata = '0;
		case (region)
			`SOC_REGION_RAM: begin
				o_bus_ready = i_ram_ready;
				o_bus_rdata = i_ram_rdata;
			end
			`SOC_REGION_LED: begin
				o_bus_ready = i_led_ready;
				o_bus_rdata = i_led_rdata;
			end
			`SOC_REGION_TIMER: begin
				o_bus_ready = i_timer_ready;
				o_bus_rdata = i_timer_rdata;
			end
			default: o_bus_rdata = '0;
		endcase
	end

	// Never two slaves on the bus
	assert property (@(posedge clock) disable iff (!i_rst_n)
		$onehot0({o_ram_select, o_led_select, o_timer_select}));

	// A slave only replies one cycle after its own select
	assert property (@(posedge clock) disable iff (!i_rst_n)
		(i_ram_ready || i_led_ready || i_timer_ready) |->
			$past(o_ram_select || o_led_select || o_timer_select));

endmodule

/* src/bus_arbiter.sv */
// Three-port fixed-priority bus arbiter, grant held until the slave replies
`timescale 1ns/1ps
`include "soc_bus_config.svh"

module bus_arbiter (
	input  logic                   clock,
	input  logic                   i_rst_n,
	// Port A, instruction reads
	input  logic                   i_pa_request,
	input  soc_bus_pkg::bus_addr_t i_pa_address,
	output logic                   o_pa_ready,
	output soc_bus_pkg::bus_word_t o_pa_rdata,
	// Port B, data
	input  logic                   i_pb_request,
	input  logic                   i_pb_rw,
	input  soc_bus_pkg::bus_addr_t i_pb_address,
	input  soc_bus_pkg::bus_word_t i_pb_wdata,
	output logic                   o_pb_ready,
	output soc_bus_pkg::bus_word_t o_pb_rdata,
	// Port C, DMA
	input  logic                   i_pc_request,
	input  logic                   i_pc_rw,
	input  soc_bus_pkg::bus_addr_t i_pc_address,
	input  soc_bus_pkg::bus_word_t i_pc_wdata,
	output logic                   o_pc_ready,
	output soc_bus_pkg::bus_word_t o_pc_rdata,
	// Shared bus
	output logic                   o_bus_request,
	output logic                   o_bus_rw,
	output soc_bus_pkg::bus_addr_t o_bus_address,
	output soc_bus_pkg::bus_word_t o_bus_wdata,
	input  logic                   i_bus_ready,
	input  soc_bus_pkg::bus_word_t i_bus_rdata
);

	soc_bus_pkg::arb_state_t  state_q;
	soc_bus_pkg::master_sel_t grant_q;

	// ==============================
	// Grant FSM
	// ==============================
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state_q <= soc_bus_pkg::ARB_IDLE;
			grant_q <= soc_bus_pkg::MASTER_NONE;
		end else begin
			case (state_q)
				soc_bus_pkg::ARB_IDLE: begin
					// Data port first, then DMA, then fetch
					if (i_pb_request) begin
						grant_q <= soc_bus_pkg::MASTER_B;
						state_q <= soc_bus_pkg::ARB_BUSY;
					end else if (i_pc_request) begin
						grant_q <= soc_bus_pkg::MASTER_C;
						state_q <= soc_bus_pkg::ARB_BUSY;
					end else if (i_pa_request) begin
						grant_q <= soc_bus_pkg::MASTER_A;
						state_q <= soc_bus_pkg::ARB_BUSY;
					end
				end
				soc_bus_pkg::ARB_BUSY: begin
					if (i_bus_ready) begin
						grant_q <= soc_bus_pkg::MASTER_NONE;
						state_q <= soc_bus_pkg::ARB_IDLE;
					end
				end
				default: state_q <= soc_bus_pkg::ARB_IDLE;
			endcase
		end
	end

	// Granted master drives the bus, port A never writes
	always_comb begin
		o_bus_request = 1'b0;
		o_bus_rw = 1'b0;
		o_bus_address = '0;
		o_bus_wdata = '0;
		case (grant_q)
			soc_bus_pkg::MASTER_A: begin
				o_bus_request = i_pa_request;
				o_bus_address = i_pa_address;
			end
			soc_bus_pkg::MASTER_B: begin
				o_bus_request = i_pb_request;
				o_bus_rw = i_pb_rw;
				o_bus_address = i_pb_address;
				o_bus_wdata = i_pb_wdata;
			end
			soc_bus_pkg::MASTER_C: begin
				o_bus_request = i_pc_request;
				o_bus_rw = i_pc_rw;
				o_bus_address = i_pc_address;
				o_bus_wdata = i_pc_wdata;
			end
			default: o_bus_request = 1'b0;
		endcase
	end

	// Reply routing
	assign o_pa_ready = i_bus_ready && (grant_q == soc_bus_pkg::MASTER_A);
	assign o_pb_ready = i_bus_ready && (grant_q == soc_bus_pkg::MASTER_B);
	assign o_pc_ready = i_bus_ready && (grant_q == soc_bus_pkg::MASTER_C);
	assign o_pa_rdata = (grant_q == soc_bus_pkg::MASTER_A) ? i_bus_rdata : '0;
	assign o_pb_rdata = (grant_q == soc_bus_pkg::MASTER_B) ? i_bus_rdata : '0;
	assign o_pc_rdata = (grant_q == soc_bus_pkg::MASTER_C) ? i_bus_rdata : '0;

	// A slave reply lands only inside a grant and reaches exactly one port
	assert property (@(posedge clock) disable iff (!i_rst_n)
		i_bus_ready |-> (state_q == soc_bus_pkg::ARB_BUSY) &&
			$onehot({o_pa_ready, o_pb_ready, o_pc_ready}));

endmodule

/* src/soc_bus_pkg.sv */
// System bus types shared by the arbiter, the decoder and the slaves
`include "soc_bus_config.svh"

package soc_bus_pkg;

	// ==============================
	// Bus payload
	// ==============================
	typedef logic [`SOC_DATA_W-1:0] bus_word_t;
	typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;

	// Slave region, top address nibble
	typedef logic [`SOC_REGION_MSB-`SOC_REGION_LSB:0] region_t;

	// Register index inside a peripheral, address bits 3:2
	typedef logic [1:0] reg_index_t;

	// ==============================
	// Arbitration
	// ==============================
	typedef enum logic [1:0] {
		MASTER_NONE = 2'd0,
		MASTER_A    = 2'd1,
		MASTER_B    = 2'd2,
		MASTER_C    = 2'd3
	} master_sel_t;

	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_BUSY = 1'b1
	} arb_state_t;

endpackage

/* src/soc_bus_config.svh */
// System bus configuration: widths, region codes, memory depth and timer prescale
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

// ==============================
// Bus widths
// ==============================
`define SOC_DATA_W 32
`define SOC_ADDR_W 32

// Top nibble of the address selects the slave
`define SOC_REGION_MSB 31
`define SOC_REGION_LSB 28

// ==============================
// Address map
// ==============================
`define SOC_REGION_RAM   4'h1
`define SOC_REGION_LED   4'h4
`define SOC_REGION_TIMER 4'hA

// ==============================
// Slave sizing
// ==============================
// On-chip RAM depth in 32-bit words
`define SOC_RAM_WORDS 1024

// LED bank width
`define SOC_LED_W 10

// Clock cycles per timer tick
`define SOC_TIMER_PRESCALE 4

`endif
